// ==== src/ringBridgePkg.sv ====
// Ring bridge package holding the ring message types, operation codes and address regions
`default_nettype none

package ringBridgePkg;

	// geometry of the victim cache
	localparam int lineOffsetBits = 4;  // byte offset bits within a 16-byte line
	localparam int defaultWays = 4;
	localparam int defaultSetBits = 6;

	// position of the no-cache flag in the mode word
	localparam int noCacheBit = 11;

	// address regions, taken from addr[47:44]
	localparam logic [3:0] regionCached = 4'hC;
	localparam logic [3:0] regionFlush = 4'hD;

	// mode byte layout
	// bits 7:6 give the class, bits 5:4 the response kind
	localparam logic [1:0] opmClassReq = 2'b10;
	localparam logic [1:0] opmClassResp = 2'b01;
	localparam logic [1:0] opmKindLdResp = 2'b11;

	// operation codes in the low mode byte
	localparam logic [7:0] opmIdle = 8'h00;
	localparam logic [7:0] opmLdx = 8'h83;
	localparam logic [7:0] opmLdxc = 8'h87;
	localparam logic [7:0] opmPfx = 8'h8B;
	localparam logic [7:0] opmSpx = 8'h8F;
	localparam logic [7:0] opmStx = 8'hA3;
	localparam logic [7:0] opmStxc = 8'hA7;
	localparam logic [7:0] opmOkLd = 8'h73;  // load response with OK status

	typedef logic [127:0] tile_t;

	// line tag is address bits 31:4
	typedef logic [31-lineOffsetBits:0] lineTag_t;

	// one ring slot as it travels on either ring
	typedef struct packed {
		logic [15:0] seq;
		logic [15:0] opm;
		logic [47:0] addr;
		tile_t data;
	} ringMsg_t;

	// flags decoded once at capture
	typedef struct packed {
		logic isIdle;
		logic isLoadReq;
		logic isStoreReq;
		logic isReq;          // any load or store request
		logic isOwnLoadResp;  // load response with our node in seq
		logic isOtherResp;    // any response for another node
		logic isCacheable;
		logic isFlush;
		logic storeAllowed;   // above the low 16M
	} ringClass_t;

	typedef struct packed {
		ringMsg_t msg;
		ringClass_t cls;
	} ringSlot_t;

endpackage

`default_nettype wire

// ==== src/wayArray.sv ====
// Way array holding all ways of one payload per set with a whole-set write port
`default_nettype none

module wayArray #(
	parameter int numWays = ringBridgePkg::defaultWays,
	parameter int setBits = ringBridgePkg::defaultSetBits,
	parameter type payload_t = logic [7:0]
) (
	input wire clock,
	input wire [setBits-1:0] readSet,
	output payload_t [numWays-1:0] readWays,
	input wire writeEnable,
	input wire [setBits-1:0] writeSet,
	input wire payload_t [numWays-1:0] writeWays
);

	localparam int numSets = 2 ** setBits;

	payload_t [numWays-1:0] mem [numSets];

	// read is combinational so a lookup sees last slot's write
	assign readWays = mem[readSet];

	always_ff @(posedge clock) begin
		if (writeEnable)
			mem[writeSet] <= writeWays;  // all ways at once
	end

endmodule

`default_nettype wire

// ==== src/ringCapture.sv ====
// Ring capture stage that registers both ring inputs and decodes their class flags
`default_nettype none

module ringCapture (
	input wire clock,
	input wire reset,
	input wire [7:0] nodeId,
	input wire ringBridgePkg::ringMsg_t l1In,
	input wire ringBridgePkg::ringMsg_t l2In,
	output ringBridgePkg::ringSlot_t l1Slot,
	output ringBridgePkg::ringSlot_t l2Slot
);

	import ringBridgePkg::*;

	localparam ringClass_t idleClass = '{isIdle: 1'b1, default: 1'b0};

	function automatic ringClass_t classify(ringMsg_t msg, logic [7:0] node);
		ringClass_t cls;
		logic [7:0] mode;
		logic isResp;
		logic ownSeq;
		logic inCachedSpace;
		mode = msg.opm[7:0];
		isResp = (mode[7:6] == opmClassResp);
		ownSeq = (msg.seq[15:10] == node[7:2]);  // node number lives in the top of seq
		inCachedSpace = (msg.addr[47:44] == regionCached) && (msg.addr[43:32] == '0);

		cls.isIdle = (mode == opmIdle);
		cls.isLoadReq = (mode == opmLdx) || (mode == opmLdxc) ||
			(mode == opmPfx) || (mode == opmSpx);
		cls.isStoreReq = (mode == opmStx) || (mode == opmStxc);
		cls.isReq = cls.isLoadReq || cls.isStoreReq;
		cls.isOwnLoadResp = isResp && ownSeq && (mode[5:4] == opmKindLdResp);
		cls.isOtherResp = isResp && !ownSeq;
		cls.isCacheable = inCachedSpace && !msg.opm[noCacheBit];
		cls.isFlush = (msg.addr[47:44] == regionFlush) || msg.opm[noCacheBit];
		cls.storeAllowed = (msg.addr[31:24] != '0);
		return cls;
	endfunction

	always_ff @(posedge clock) begin
		l1Slot.msg <= l1In;
		l1Slot.cls <= classify(l1In, nodeId);
		l2Slot.msg <= l2In;
		l2Slot.cls <= classify(l2In, nodeId);
		if (reset) begin
			// both rings look idle while reset is high
			l1Slot.msg.seq <= '0;
			l1Slot.msg.opm <= '0;
			l1Slot.cls <= idleClass;
			l2Slot.msg.seq <= '0;
			l2Slot.msg.opm <= '0;
			l2Slot.cls <= idleClass;
		end
	end

	// stores carry mode bit 5, loads never do, so no slot is both
	loadStoreExclusive: assert property (@(posedge clock) disable iff (reset)
		!(l1Slot.cls.isLoadReq && l1Slot.msg.opm[5]) &&
		!(l1Slot.cls.isStoreReq && !l1Slot.msg.opm[5]) &&
		!(l2Slot.cls.isLoadReq && l2Slot.msg.opm[5]) &&
		!(l2Slot.cls.isStoreReq && !l2Slot.msg.opm[5]))
		else $error("captured slot decoded as both load and store");

endmodule

`default_nettype wire

// ==== src/victimLookup.sv ====
// Victim cache lookup with hit selection and fill, store and flush updates
`default_nettype none

module victimLookup #(
	parameter int numWays = ringBridgePkg::defaultWays,
	parameter int setBits = ringBridgePkg::defaultSetBits
) (
	input wire clock,
	input wire reset,
	input wire ringBridgePkg::ringSlot_t l1Slot,
	input wire ringBridgePkg::ringSlot_t l2Slot,
	output logic hit,
	output ringBridgePkg::tile_t hitData
);

	import ringBridgePkg::*;

	localparam int numSets = 2 ** setBits;

	logic fill;
	logic storeInsert;
	logic fillInsert;
	logic doInsert;
	logic doFlush;
	logic arrayWrite;
	logic [setBits-1:0] setIdx;
	logic [numWays-1:0] setValid;
	logic [numWays-1:0] wayMatch;
	logic [numSets-1:0][numWays-1:0] validBits;
	lineTag_t l1Tag;
	lineTag_t newTag;
	tile_t newData;
	lineTag_t [numWays-1:0] tagWays;
	lineTag_t [numWays-1:0] tagWrite;
	tile_t [numWays-1:0] dataWays;
	tile_t [numWays-1:0] dataWrite;

	// L2 fill borrows the set port when L1 has nothing for the cache
	// a flush on L1 keeps the port and the fill is dropped
	assign fill = l2Slot.cls.isOwnLoadResp && !l1Slot.cls.isLoadReq &&
		!l1Slot.cls.isStoreReq && !l1Slot.cls.isFlush;
	assign setIdx = fill ? l2Slot.msg.addr[lineOffsetBits +: setBits] :
		l1Slot.msg.addr[lineOffsetBits +: setBits];
	assign l1Tag = l1Slot.msg.addr[31:lineOffsetBits];
	assign setValid = validBits[setIdx];

	wayArray #(
		.numWays(numWays),
		.setBits(setBits),
		.payload_t(lineTag_t)
	) tagArray_inst (
		.clock(clock),
		.readSet(setIdx),
		.readWays(tagWays),
		.writeEnable(arrayWrite),
		.writeSet(setIdx),
		.writeWays(tagWrite)
	);

	wayArray #(
		.numWays(numWays),
		.setBits(setBits),
		.payload_t(tile_t)
	) dataArray_inst (
		.clock(clock),
		.readSet(setIdx),
		.readWays(dataWays),
		.writeEnable(arrayWrite),
		.writeSet(setIdx),
		.writeWays(dataWrite)
	);

	always_comb begin
		for (int w = 0; w < numWays; w++) begin
			wayMatch[w] = setValid[w] && (tagWays[w] == l1Tag);
		end
	end

	// lowest matching way wins
	always_comb begin
		hitData = dataWays[0];
		for (int w = numWays - 1; w >= 0; w--) begin
			if (wayMatch[w])
				hitData = dataWays[w];
		end
	end

	assign hit = l1Slot.cls.isLoadReq && l1Slot.cls.isCacheable && (|wayMatch);

	assign storeInsert = l1Slot.cls.isStoreReq && l1Slot.cls.isCacheable &&
		l1Slot.cls.storeAllowed;
	assign fillInsert = fill && l2Slot.cls.isCacheable;
	assign doInsert = storeInsert || fillInsert;
	assign doFlush = l1Slot.cls.isFlush;
	assign arrayWrite = doInsert && !doFlush;  // flush touches only valid bits

	assign newTag = storeInsert ? l1Tag : l2Slot.msg.addr[31:lineOffsetBits];
	assign newData = storeInsert ? l1Slot.msg.data : l2Slot.msg.data;

	// new line enters way 0, the oldest falls off the end
	always_comb begin
		tagWrite[0] = newTag;
		dataWrite[0] = newData;
		for (int w = 1; w < numWays; w++) begin
			tagWrite[w] = tagWays[w-1];
			dataWrite[w] = dataWays[w-1];
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			validBits <= '0;
		else if (doFlush)
			validBits[setIdx] <= setValid & ~wayMatch;
		else if (doInsert)
			validBits[setIdx] <= {setValid[numWays-2:0], 1'b1};
	end

	// class flags against the raw mode byte from capture
	hitIsLoad: assert property (@(posedge clock) disable iff (reset)
		hit |-> (l1Slot.msg.opm[7:6] == opmClassReq) && !l1Slot.msg.opm[noCacheBit])
		else $error("cache hit on a slot that is not a cacheable load request");

	insertNotFlush: assert property (@(posedge clock) disable iff (reset)
		arrayWrite |-> (l1Slot.msg.addr[47:44] != regionFlush) &&
			!l1Slot.msg.opm[noCacheBit])
		else $error("insert and flush in the same slot");

endmodule

`default_nettype wire

// ==== src/ringSteer.sv ====
// Ring steer stage that picks and registers the message for each ring output
`default_nettype none

module ringSteer (
	input wire clock,
	input wire reset,
	input wire ringBridgePkg::ringSlot_t l1Slot,
	input wire ringBridgePkg::ringSlot_t l2Slot,
	input wire hit,
	input wire ringBridgePkg::tile_t hitData,
	output ringBridgePkg::ringMsg_t l1Out,
	output ringBridgePkg::ringMsg_t l2Out
);

	import ringBridgePkg::*;

	ringMsg_t l1Next;
	ringMsg_t l2Next;
	logic holdBack;

	// L2 traffic not meant for us stays on L2 when L1 has a free slot
	assign holdBack = (l2Slot.cls.isReq || l2Slot.cls.isOtherResp) && l1Slot.cls.isIdle;

	always_comb begin
		// default is a straight swap across the bridge
		l1Next = l2Slot.msg;
		l2Next = l1Slot.msg;
		if (holdBack) begin
			l1Next = l1Slot.msg;
			l2Next = l2Slot.msg;
		end
		if (hit) begin
			// answer the load locally
			l1Next = l1Slot.msg;
			l1Next.opm[7:4] = opmOkLd[7:4];
			l1Next.data = hitData;
			l2Next = l2Slot.msg;
		end
	end

	always_ff @(posedge clock) begin
		l1Out <= l1Next;
		l2Out <= l2Next;
		if (reset) begin
			l1Out.seq <= '0;
			l1Out.opm <= '0;
			l2Out.seq <= '0;
			l2Out.opm <= '0;
		end
	end

	// capture clears its slots too, so the cycle after reset is idle
	idleAfterReset: assert property (@(posedge clock)
		$fell(reset) |=> (l1Out.opm == '0) && (l2Out.opm == '0))
		else $error("ring output not idle in the cycle after reset");

endmodule

`default_nettype wire

// ==== src/ringBridge.sv ====
// Ring bridge top level that passes messages between the L1 and L2 rings beside a victim cache
`default_nettype none

module ringBridge #(
	parameter int numWays = ringBridgePkg::defaultWays,
	parameter int setBits = ringBridgePkg::defaultSetBits
) (
	input wire clock,
	input wire reset,
	input wire [7:0] nodeId,
	input wire ringBridgePkg::ringMsg_t l1In,
	input wire ringBridgePkg::ringMsg_t l2In,
	output ringBridgePkg::ringMsg_t l1Out,
	output ringBridgePkg::ringMsg_t l2Out
);

	import ringBridgePkg::*;

	ringSlot_t l1Slot;  // captured slots, one cycle after the inputs
	ringSlot_t l2Slot;
	logic hit;
	tile_t hitData;

	ringCapture ringCapture_inst (
		.clock(clock),
		.reset(reset),
		.nodeId(nodeId),
		.l1In(l1In),
		.l2In(l2In),
		.l1Slot(l1Slot),
		.l2Slot(l2Slot)
	);

	// lookup is combinational on the captured slots
	victimLookup #(
		.numWays(numWays),
		.setBits(setBits)
	) victimLookup_inst (
		.clock(clock),
		.reset(reset),
		.l1Slot(l1Slot),
		.l2Slot(l2Slot),
		.hit(hit),
		.hitData(hitData)
	);

	ringSteer ringSteer_inst (
		.clock(clock),
		.reset(reset),
		.l1Slot(l1Slot),
		.l2Slot(l2Slot),
		.hit(hit),
		.hitData(hitData),
		.l1Out(l1Out),
		.l2Out(l2Out)
	);

endmodule

`default_nettype wire

// ==== verif/ringBridgeTb.sv ====
// Ring bridge testbench that runs a stimulus table against a reference victim cache model
`default_nettype none

module ringBridgeTb;

	import ringBridgePkg::*;

	localparam logic [47:0] lineA = 48'hC000_1200_0040;  // set 4
	localparam logic [47:0] lineS = 48'hC000_3400_0080;
	localparam logic [47:0] lineLow = 48'hC000_0050_0090;  // below 16M, never cached
	// five lines that all land in set 4
	localparam logic [47:0] lineR [5] = '{48'hC000_1200_0440, 48'hC000_1200_0840,
		48'hC000_1200_0C40, 48'hC000_1200_1040, 48'hC000_1200_1440};

	logic clock;
	logic reset;
	logic [7:0] nodeId;
	ringMsg_t l1In;
	ringMsg_t l2In;
	ringMsg_t l1Out;
	ringMsg_t l2Out;

	int seed = 32'h720c;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit;
	ringMsg_t l1Tab[$];
	ringMsg_t l2Tab[$];
	logic hitTab[$];  // table column: L1 answered locally
	ringMsg_t expL1[$];
	ringMsg_t expL2[$];

	// reference cache, way 0 is the newest line
	bit [27:0] modelTag [64][4];
	tile_t modelData [64][4];
	bit modelValid [64][4];

	ringBridge ringBridge_inst (
		.clock(clock),
		.reset(reset),
		.nodeId(nodeId),
		.l1In(l1In),
		.l2In(l2In),
		.l1Out(l1Out),
		.l2Out(l2Out)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the stimulus table did not finish", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic tile_t randomTile();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic ringMsg_t makeMsg(logic [15:0] seq, logic [15:0] opm,
		logic [47:0] addr);
		ringMsg_t m;
		m.seq = seq;
		m.opm = opm;
		m.addr = addr;
		m.data = randomTile();
		return m;
	endfunction

	function automatic ringMsg_t idleMsg();
		return makeMsg(16'h0000, 16'h0000, 48'h0);
	endfunction

	function automatic logic isLoadOp(logic [7:0] op);
		return op inside {opmLdx, opmLdxc, opmPfx, opmSpx};
	endfunction

	function automatic logic isStoreOp(logic [7:0] op);
		return op inside {opmStx, opmStxc};
	endfunction

	function automatic logic inCachedRegion(ringMsg_t m);
		return (m.addr[47:44] == regionCached) && (m.addr[43:32] == 12'h0) && !m.opm[noCacheBit];
	endfunction

	function automatic logic fromThisNode(ringMsg_t m);
		return m.seq[15:10] == nodeId[7:2];
	endfunction

	task automatic addStep(ringMsg_t l1, ringMsg_t l2, logic expHit);
		l1Tab.push_back(l1);
		l2Tab.push_back(l2);
		hitTab.push_back(expHit);
	endtask

	task automatic insertLine(logic [5:0] set, bit [27:0] tag, tile_t data);
		for (int w = 3; w > 0; w--) begin
			modelTag[set][w] = modelTag[set][w-1];
			modelData[set][w] = modelData[set][w-1];
			modelValid[set][w] = modelValid[set][w-1];
		end
		modelTag[set][0] = tag;
		modelData[set][0] = data;
		modelValid[set][0] = 1'b1;
	endtask

	task automatic predictStep(input ringMsg_t a, input ringMsg_t b, output ringMsg_t toL1,
		output ringMsg_t toL2, output logic predHit);
		logic aFlush;
		logic bOwnLoad;
		logic bForeign;
		logic [5:0] set;
		bit [27:0] tag;
		tile_t found;
		aFlush = (a.addr[47:44] == regionFlush) || a.opm[noCacheBit];
		bOwnLoad = (b.opm[7:6] == 2'b01) && (b.opm[5:4] == 2'b11) && fromThisNode(b);
		bForeign = isLoadOp(b.opm[7:0]) || isStoreOp(b.opm[7:0]) ||
			((b.opm[7:6] == 2'b01) && !fromThisNode(b));
		set = a.addr[9:4];
		tag = a.addr[31:4];
		predHit = 1'b0;
		found = '0;
		for (int w = 3; w >= 0; w--) begin  // lowest matching way wins
			if (modelValid[set][w] && modelTag[set][w] == tag) begin
				found = modelData[set][w];
				predHit = isLoadOp(a.opm[7:0]) && inCachedRegion(a);
			end
		end
		toL1 = b;
		toL2 = a;
		if (bForeign && a.opm[7:0] == opmIdle) begin
			toL1 = a;
			toL2 = b;
		end
		if (predHit) begin
			toL1 = a;
			toL1.opm[7:4] = opmOkLd[7:4];
			toL1.data = found;
			toL2 = b;
		end
		if (aFlush) begin
			for (int w = 0; w < 4; w++) begin
				if (modelTag[set][w] == tag)
					modelValid[set][w] = 1'b0;
			end
		end else if (isStoreOp(a.opm[7:0]) && inCachedRegion(a) && a.addr[31:24] != 8'h00) begin
			insertLine(set, tag, a.data);
		end else if (bOwnLoad && !isLoadOp(a.opm[7:0]) && !isStoreOp(a.opm[7:0]) &&
			inCachedRegion(b)) begin
			insertLine(b.addr[9:4], b.addr[31:4], b.data);  // fill from L2
		end
	endtask

	task automatic buildTable();
		addStep(idleMsg(), idleMsg(), 1'b0);
		addStep(makeMsg(16'h1401, {8'h00, opmStx}, 48'h1000_5600_0100),
			makeMsg(16'h1402, {8'h00, opmOkLd}, 48'hB000_0000_0200), 1'b0);
		// L2 traffic that is not ours stays on L2
		addStep(idleMsg(), makeMsg(16'h2c03, {8'h00, opmLdx}, 48'h2000_0000_0300), 1'b0);
		addStep(idleMsg(), makeMsg(16'h2c04, {8'h00, opmOkLd}, 48'h2000_0000_0400), 1'b0);
		addStep(idleMsg(), makeMsg(16'h1405, {8'h00, opmOkLd}, 48'h2000_0000_0500), 1'b0);
		// fill then hit, then uncached region and no-cache flag
		addStep(idleMsg(), makeMsg(16'h1406, {8'h00, opmOkLd}, lineA), 1'b0);
		addStep(makeMsg(16'h1407, {8'h00, opmLdx}, lineA), idleMsg(), 1'b1);
		addStep(makeMsg(16'h1408, {8'h00, opmLdx}, 48'hB000_1200_0040), idleMsg(), 1'b0);
		addStep(makeMsg(16'h1409, {8'h08, opmLdx}, lineA), idleMsg(), 1'b0);  // flushes too
		addStep(makeMsg(16'h140a, {8'h00, opmLdxc}, lineA), idleMsg(), 1'b0);
		addStep(makeMsg(16'h140b, {8'h00, opmStx}, lineS), idleMsg(), 1'b0);
		addStep(makeMsg(16'h140c, {8'h00, opmLdx}, lineS),
			makeMsg(16'h2c0d, {8'h00, opmLdx}, 48'h2000_0000_0600), 1'b1);
		addStep(makeMsg(16'h140e, {8'h00, opmStx}, lineLow), idleMsg(), 1'b0);
		addStep(makeMsg(16'h140f, {8'h00, opmLdx}, lineLow), idleMsg(), 1'b0);
		// five lines into one set, oldest falls out
		addStep(idleMsg(), makeMsg(16'h1410, {8'h00, opmOkLd}, lineR[0]), 1'b0);
		for (int k = 1; k < 5; k++)
			addStep(makeMsg(16'h1411, {8'h00, opmStxc}, lineR[k]), idleMsg(), 1'b0);
		addStep(makeMsg(16'h1412, {8'h00, opmLdx}, lineR[0]), idleMsg(), 1'b0);
		for (int k = 1; k < 5; k++)
			addStep(makeMsg(16'h1413, {8'h00, opmLdx}, lineR[k]), idleMsg(), 1'b1);
		addStep(makeMsg(16'h1414, {8'h00, opmLdx}, 48'hD000_1200_0C40), idleMsg(), 1'b0);
		addStep(makeMsg(16'h1415, {8'h00, opmLdx}, lineR[2]), idleMsg(), 1'b0);
		addStep(makeMsg(16'h1416, {8'h00, opmPfx}, lineR[3]), idleMsg(), 1'b1);
		addStep(makeMsg(16'h1417, {8'h00, opmLdx}, lineR[1]), idleMsg(), 1'b1);
		addStep(idleMsg(), idleMsg(), 1'b0);
	endtask

	task automatic checkIdle();
		checks++;
		if (l1Out.seq !== 16'h0 || l1Out.opm !== 16'h0) begin
			errors++;
			$display("[ERROR] l1Out seq/opm got %h/%h expected 0000/0000", l1Out.seq, l1Out.opm);
		end
		if (l2Out.seq !== 16'h0 || l2Out.opm !== 16'h0) begin
			errors++;
			$display("[ERROR] l2Out seq/opm got %h/%h expected 0000/0000", l2Out.seq, l2Out.opm);
		end
	endtask

	task automatic compareMsg(string name, ringMsg_t got, ringMsg_t exp, int step);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] step %0d %s got %h expected %h", step, name, got, exp);
		end
	endtask

	initial begin
		ringMsg_t predL1;
		ringMsg_t predL2;
		logic predHit;
		int numSteps;
		reset = 1'b1;
		nodeId = 8'h14;  // node 5 in seq bits 15:10
		l1In = '0;
		l2In = '0;
		buildTable();
		numSteps = l1Tab.size();
		limit = 2 * numSteps + 40;
		repeat (15) begin
			@(negedge clock);
			checkIdle();
		end
		for (int j = 0; j < numSteps + 2; j++) begin
			@(negedge clock);
			if (j == 0)
				reset = 1'b0;  // sixteenth rising edge had reset high
			// outputs trail the inputs by two slots
			if (j < 2) begin
				checkIdle();
			end else begin
				compareMsg("l1Out", l1Out, expL1[j-2], j - 2);
				compareMsg("l2Out", l2Out, expL2[j-2], j - 2);
			end
			if (j < numSteps) begin
				predictStep(l1Tab[j], l2Tab[j], predL1, predL2, predHit);
				if (predHit !== hitTab[j]) begin
					errors++;
					$display("step %0d: the table and the reference model disagree on a hit", j);
				end
				expL1.push_back(predL1);
				expL2.push_back(predL2);
				l1In = l1Tab[j];
				l2In = l2Tab[j];
			end else begin
				l1In = '0;
				l2In = '0;
			end
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ringBridge.f ====
src/ringBridgePkg.sv
src/wayArray.sv
src/ringCapture.sv
src/victimLookup.sv
src/ringSteer.sv
src/ringBridge.sv
verif/ringBridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the ring bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log

verilator --binary --timing --assert -f ringBridge.f --top-module ringBridgeTb \
	-Mdir "$buildDir" -o simRingBridge
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"$buildDir/simRingBridge" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "RESULT: FAIL" "$logFile"; then
	exit 1
fi
exit 0
